//--- flist.f
src/rps_pkg.sv
src/round_if.sv
src/round_ctrl.sv
src/markov_predictor.sv
src/score_keeper.sv
src/seven_seg_bank.sv
src/rps_game.sv
testbench/rps_game_assertions.sv
testbench/rps_game_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rps_game testbench, fail if the log reports a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rps_game_tb \
	-Mdir obj_dir -f flist.f \
	&& ./obj_dir/Vrps_game_tb > sim.log 2>&1 \
	|| echo "Test failed" >> sim.log
cat sim.log
! grep -q "Test failed" sim.log

//--- src/markov_predictor.sv
// markov_predictor: transition count table and counter-move choice
`timescale 1ns/1ns

module markov_predictor #(
	parameter int count_width = 8
) (
	input  logic       clock,
	input  logic       reset,
	round_if.predictor rnd
);

	localparam int num_states = rps_pkg::num_moves * rps_pkg::num_moves;

	logic [count_width-1:0] counts [num_states][rps_pkg::num_moves];
	rps_pkg::state_t        prev_state;
	logic                   prev_valid;
	rps_pkg::state_t        cur_state;
	logic [count_width-1:0] row [rps_pkg::num_moves];
	logic [count_width-1:0] best_count;
	rps_pkg::move_t         likely; // most frequent next user move

	// the move that beats m
	function automatic rps_pkg::move_t counter_move(input rps_pkg::move_t m);
		case (m)
			rps_pkg::move_rock:    return rps_pkg::move_paper;
			rps_pkg::move_scissor: return rps_pkg::move_rock;
			default:               return rps_pkg::move_scissor;
		endcase
	endfunction

	assign cur_state = rps_pkg::state_t'(rnd.user_move * rps_pkg::num_moves + rnd.comp_move);

	always_comb begin
		for (int m = 0; m < rps_pkg::num_moves; m++) begin
			row[m] = prev_valid ? counts[prev_state][m] : '0;
		end
	end

	// strict compare keeps ties in rock, scissor, paper order
	always_comb begin
		likely     = rps_pkg::move_rock;
		best_count = row[0];
		if (row[1] > best_count) begin
			likely     = rps_pkg::move_scissor;
			best_count = row[1];
		end
		if (row[2] > best_count) begin
			likely     = rps_pkg::move_paper;
		end
	end

	assign rnd.prediction = counter_move(likely);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int s = 0; s < num_states; s++) begin
				for (int m = 0; m < rps_pkg::num_moves; m++) begin
					counts[s][m] <= '0;
				end
			end
			prev_state <= '0;
			prev_valid <= 1'b0;
		end else if (rnd.commit && rnd.user_move <= rps_pkg::move_paper) begin
			// rounds with an illegal user move leave the history alone
			if (prev_valid && counts[prev_state][rnd.user_move] != '1) begin
				counts[prev_state][rnd.user_move] <= counts[prev_state][rnd.user_move] + 1'b1;
			end
			prev_state <= cur_state;
			prev_valid <= 1'b1;
		end
	end

endmodule

//--- src/round_ctrl.sv
// round_ctrl: req/ack sequencer, rotating opponent and strategy select
`timescale 1ns/1ns

module round_ctrl (
	input  logic               clock,
	input  logic               reset,
	input  logic               play_req,
	input  rps_pkg::strategy_t strategy,
	input  rps_pkg::move_t     user_move,
	output logic               play_ack,
	output rps_pkg::move_t     comp_move,
	round_if.ctrl              rnd
);

	typedef enum logic [1:0] {st_idle, st_commit, st_hold} seq_t;

	seq_t               state;
	rps_pkg::move_t     user_q;
	rps_pkg::strategy_t strategy_q;
	rps_pkg::move_t     rot_q; // rotating opponent
	logic               commit_q;

	assign rnd.user_move = user_q;
	assign rnd.commit    = commit_q;
	assign rnd.comp_move = (strategy_q == rps_pkg::strategy_markov) ? rnd.prediction : rot_q;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state      <= st_idle;
			user_q     <= rps_pkg::move_rock;
			strategy_q <= rps_pkg::strategy_rotate;
			rot_q      <= rps_pkg::move_rock;
			commit_q   <= 1'b0;
			play_ack   <= 1'b0;
			comp_move  <= rps_pkg::move_rock;
		end else begin
			case (state)
				st_idle: if (play_req) begin
					user_q     <= user_move; // inputs are stable while req is high
					strategy_q <= strategy;
					state      <= st_commit;
				end
				st_commit: begin
					commit_q <= 1'b1;
					state    <= st_hold;
				end
				st_hold: if (commit_q) begin
					commit_q  <= 1'b0;
					play_ack  <= 1'b1;
					comp_move <= rnd.comp_move;
					// rock -> scissor -> paper, once per round whatever the strategy
					rot_q     <= (rot_q == rps_pkg::move_paper) ? rps_pkg::move_rock
						: rot_q + 2'd1;
				end else if (!play_req) begin
					play_ack <= 1'b0; // held req stalls here
					state    <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- src/round_if.sv
// round_if: one round between the controller, the Markov predictor and the scorer
`timescale 1ns/1ns

interface round_if;

	rps_pkg::move_t user_move; // latched user move
	rps_pkg::move_t comp_move; // computer move for this round
	logic commit;              // one-cycle strobe, results update on it
	rps_pkg::move_t prediction; // Markov counter-move

	modport ctrl (
		output user_move,
		output comp_move,
		output commit,
		input  prediction
	);

	modport predictor (
		input  user_move,
		input  comp_move,
		input  commit,
		output prediction
	);

	modport scorer (input user_move, input comp_move, input commit);

endinterface

//--- src/rps_game.sv
// rps_game: top level wiring of round controller, predictor, scorer and digit bank
`timescale 1ns/1ns

module rps_game #(
	parameter int score_width = 8,
	parameter int count_width = 8
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    play_req,
	input  rps_pkg::strategy_t      strategy,
	input  rps_pkg::move_t          user_move,
	output logic                    play_ack,
	output rps_pkg::move_t          comp_move,
	output rps_pkg::outcome_t       outcome,
	output logic [score_width-1:0]  user_score,
	output logic [score_width-1:0]  comp_score,
	output rps_pkg::seg_t           hex0,
	output rps_pkg::seg_t           hex1,
	output rps_pkg::seg_t           hex2,
	output rps_pkg::seg_t           hex3,
	output rps_pkg::seg_t           hex4,
	output rps_pkg::seg_t           hex5
);

	round_if rnd ();

	round_ctrl ctrl0 (
		.clock     (clock),
		.reset     (reset),
		.play_req  (play_req),
		.strategy  (strategy),
		.user_move (user_move),
		.play_ack  (play_ack),
		.comp_move (comp_move),
		.rnd       (rnd.ctrl)
	);

	markov_predictor #(.count_width(count_width)) pred0 (
		.clock (clock),
		.reset (reset),
		.rnd   (rnd.predictor)
	);

	score_keeper #(.score_width(score_width)) score0 (
		.clock      (clock),
		.reset      (reset),
		.rnd        (rnd.scorer),
		.outcome    (outcome),
		.user_score (user_score),
		.comp_score (comp_score)
	);

	// digits follow the latched user move, so they agree with the scores
	seven_seg_bank #(.score_width(score_width)) seg0 (
		.user_move  (rnd.user_move),
		.comp_move  (comp_move),
		.user_score (user_score),
		.comp_score (comp_score),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

endmodule

//--- src/rps_pkg.sv
// rps_pkg: move, outcome, strategy, segment and state types plus move codes
package rps_pkg;

	// 2-bit move, code 3 is illegal
	typedef logic [1:0] move_t;

	localparam move_t move_rock    = 2'd0;
	localparam move_t move_scissor = 2'd1;
	localparam move_t move_paper   = 2'd2;

	// round result as seen from the user
	typedef enum logic [1:0] {
		outcome_none,
		outcome_user_win,
		outcome_comp_win,
		outcome_draw
	} outcome_t;

	// opponent select
	typedef enum logic {
		strategy_rotate,
		strategy_markov
	} strategy_t;

	// one active-low digit, segment a in bit 0
	typedef logic [6:0] seg_t;

	// moves per player, sizes the count table
	localparam int num_moves = 3;

	// (user, comp) pair index = user * num_moves + comp, range 0..8
	typedef logic [3:0] state_t;

endpackage

//--- src/score_keeper.sv
// score_keeper: referee rules, outcome flags and saturating scores
`timescale 1ns/1ns

module score_keeper #(
	parameter int score_width = 8
) (
	input  logic                   clock,
	input  logic                   reset,
	round_if.scorer                rnd,
	output rps_pkg::outcome_t      outcome,
	output logic [score_width-1:0] user_score,
	output logic [score_width-1:0] comp_score
);

	rps_pkg::outcome_t next_outcome;
	logic              user_beats;

	assign user_beats =
		(rnd.user_move == rps_pkg::move_rock    && rnd.comp_move == rps_pkg::move_scissor) ||
		(rnd.user_move == rps_pkg::move_scissor && rnd.comp_move == rps_pkg::move_paper) ||
		(rnd.user_move == rps_pkg::move_paper   && rnd.comp_move == rps_pkg::move_rock);

	always_comb begin
		if (rnd.user_move > rps_pkg::move_paper) begin
			next_outcome = rps_pkg::outcome_none; // illegal move, no score change
		end else if (rnd.user_move == rnd.comp_move) begin
			next_outcome = rps_pkg::outcome_draw;
		end else if (user_beats) begin
			next_outcome = rps_pkg::outcome_user_win;
		end else begin
			next_outcome = rps_pkg::outcome_comp_win;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			outcome    <= rps_pkg::outcome_none;
			user_score <= '0;
			comp_score <= '0;
		end else if (rnd.commit) begin
			outcome <= next_outcome;
			if (next_outcome == rps_pkg::outcome_user_win && user_score != '1) begin
				user_score <= user_score + 1'b1; // saturates at all ones
			end
			if (next_outcome == rps_pkg::outcome_comp_win && comp_score != '1) begin
				comp_score <= comp_score + 1'b1;
			end
		end
	end

endmodule

//--- src/seven_seg_bank.sv
// seven_seg_bank: hex font decode of moves and score nibbles onto six digits
`timescale 1ns/1ns

module seven_seg_bank #(
	parameter int score_width = 8
) (
	input  rps_pkg::move_t         user_move,
	input  rps_pkg::move_t         comp_move,
	input  logic [score_width-1:0] user_score,
	input  logic [score_width-1:0] comp_score,
	output rps_pkg::seg_t          hex0,
	output rps_pkg::seg_t          hex1,
	output rps_pkg::seg_t          hex2,
	output rps_pkg::seg_t          hex3,
	output rps_pkg::seg_t          hex4,
	output rps_pkg::seg_t          hex5
);

	logic [7:0] user_byte;
	logic [7:0] comp_byte;

	// active-low font, segment a in bit 0
	function automatic rps_pkg::seg_t hex_font(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110; // F
		endcase
	endfunction

	assign user_byte = 8'(user_score); // two digits per score
	assign comp_byte = 8'(comp_score);

	assign hex0 = hex_font(user_byte[3:0]);
	assign hex1 = hex_font(user_byte[7:4]);
	assign hex2 = hex_font({2'b00, user_move});
	assign hex3 = hex_font({2'b00, comp_move});
	assign hex4 = hex_font(comp_byte[3:0]);
	assign hex5 = hex_font(comp_byte[7:4]);

endmodule

//--- testbench/rps_game_assertions.sv
// rps_game_assertions: bound handshake and result validity checks for rps_game
`timescale 1ns/1ns

module rps_game_assertions (
	input logic              clock,
	input logic              reset,
	input logic              play_req,
	input logic              play_ack,
	input rps_pkg::move_t    user_move,
	input rps_pkg::move_t    comp_move,
	input rps_pkg::outcome_t outcome
);

	ack_needs_req: assert property (@(posedge clock) disable iff (!reset)
		$rose(play_ack) |-> play_req)
		else $error("play_ack rose without a pending play_req");

	ack_low_in_reset: assert property (@(posedge clock) !reset |-> !play_ack)
		else $error("play_ack high during reset");

	// illegal code must never reach the output
	comp_move_legal: assert property (@(posedge clock) disable iff (!reset)
		play_ack |-> comp_move != 2'd3)
		else $error("comp_move holds the illegal code");

	outcome_valid: assert property (@(posedge clock) disable iff (!reset)
		(play_ack && user_move != 2'd3) |-> outcome != rps_pkg::outcome_none)
		else $error("no outcome for a legal round");

endmodule

bind rps_game rps_game_assertions asrt0 (
	.clock(clock), .reset(reset), .play_req(play_req), .play_ack(play_ack),
	.user_move(user_move), .comp_move(comp_move), .outcome(outcome)
);

//--- testbench/rps_game_tb.sv
// testbench top for rps_game with clock, reset, vector reader, reference model and compare tasks
`timescale 1ns/1ns

module rps_game_tb;

	localparam int score_width = 8;
	localparam int wait_limit = 16; // cycles allowed per handshake wait
	localparam rps_pkg::seg_t font_rom [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
		7'h02, 7'h78, 7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

	logic                   clock;
	logic                   reset;
	logic                   play_req;
	rps_pkg::strategy_t     strategy;
	rps_pkg::move_t         user_move;
	logic                   play_ack;
	rps_pkg::move_t         comp_move;
	rps_pkg::outcome_t      outcome;
	logic [score_width-1:0] user_score;
	logic [score_width-1:0] comp_score;
	rps_pkg::seg_t          hex [6];
	logic [11:0]            vectors [64]; // strategy, user move, extra hold cycles
	int                     counts [9][3]; // next user move after each pair
	int                     prev_state;
	logic                   prev_valid;
	rps_pkg::move_t         rot_move;
	rps_pkg::move_t         exp_comp;
	rps_pkg::outcome_t      exp_outcome;
	logic [score_width-1:0] exp_user_score;
	logic [score_width-1:0] exp_comp_score;

	rps_game #(.score_width(score_width), .count_width(8)) dut0 (
		.clock(clock), .reset(reset), .play_req(play_req), .strategy(strategy),
		.user_move(user_move), .play_ack(play_ack), .comp_move(comp_move), .outcome(outcome),
		.user_score(user_score), .comp_score(comp_score), .hex0(hex[0]), .hex1(hex[1]),
		.hex2(hex[2]), .hex3(hex[3]), .hex4(hex[4]), .hex5(hex[5])
	);

	always #20 clock = ~clock;

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_move(input string name, input rps_pkg::move_t got,
		input rps_pkg::move_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_outcome(input string name, input rps_pkg::outcome_t got,
		input rps_pkg::outcome_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_score(input string name, input logic [score_width-1:0] got,
		input logic [score_width-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_seg(input string name, input rps_pkg::seg_t got,
		input rps_pkg::seg_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// win when the computer holds the move one step after the user's
	function automatic rps_pkg::outcome_t referee(input rps_pkg::move_t u,
		input rps_pkg::move_t c);
		if (u == 2'd3) return rps_pkg::outcome_none;
		if (u == c) return rps_pkg::outcome_draw;
		if (int'(c) == (int'(u) + 1) % 3) return rps_pkg::outcome_user_win;
		return rps_pkg::outcome_comp_win;
	endfunction

	function automatic rps_pkg::move_t markov_pick();
		int best;
		int pick;
		int c;
		best = -1;
		pick = 0;
		for (int m = 0; m < 3; m++) begin
			c = prev_valid ? counts[prev_state][m] : 0;
			if (c > best) begin // strict compare keeps earlier moves on ties
				best = c;
				pick = m;
			end
		end
		return rps_pkg::move_t'((pick + 2) % 3); // the move two steps on beats it
	endfunction

	task automatic model_round(input rps_pkg::strategy_t s, input rps_pkg::move_t m);
		exp_comp = (s == rps_pkg::strategy_markov) ? markov_pick() : rot_move;
		rot_move = rps_pkg::move_t'((int'(rot_move) + 1) % 3); // steps every round
		exp_outcome = referee(m, exp_comp);
		if (exp_outcome == rps_pkg::outcome_user_win && exp_user_score != '1) begin
			exp_user_score++;
		end
		if (exp_outcome == rps_pkg::outcome_comp_win && exp_comp_score != '1) begin
			exp_comp_score++;
		end
		if (m != 2'd3) begin
			if (prev_valid && counts[prev_state][m] < 255) counts[prev_state][m]++;
			prev_state = int'(m) * 3 + int'(exp_comp);
			prev_valid = 1'b1;
		end
	endtask

	task automatic check_results(input rps_pkg::move_t m);
		compare_move("comp_move", comp_move, exp_comp);
		compare_outcome("outcome", outcome, exp_outcome);
		compare_score("user_score", user_score, exp_user_score);
		compare_score("comp_score", comp_score, exp_comp_score);
		compare_seg("hex0", hex[0], font_rom[exp_user_score[3:0]]);
		compare_seg("hex1", hex[1], font_rom[exp_user_score[7:4]]);
		compare_seg("hex2", hex[2], font_rom[{2'b00, m}]);
		compare_seg("hex3", hex[3], font_rom[{2'b00, exp_comp}]);
		compare_seg("hex4", hex[4], font_rom[exp_comp_score[3:0]]);
		compare_seg("hex5", hex[5], font_rom[exp_comp_score[7:4]]);
	endtask

	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (play_ack !== level) begin
			if (cycles == wait_limit) begin
				$display("timeout: play_ack did not go %s within %0d cycles",
					level ? "high" : "low", wait_limit);
				abort_run();
			end
			cycles++;
			@(negedge clock);
		end
	endtask

	initial begin
		logic [11:0] vec;
		int idx;
		clock = 1'b0;
		reset = 1'b0;
		play_req = 1'b0;
		strategy = rps_pkg::strategy_rotate;
		user_move = rps_pkg::move_rock;
		counts = '{default: 0};
		prev_state = 0;
		prev_valid = 1'b0;
		rot_move = rps_pkg::move_rock;
		exp_comp = rps_pkg::move_rock;
		exp_outcome = rps_pkg::outcome_none;
		exp_user_score = '0;
		exp_comp_score = '0;
		for (int i = 0; i < 64; i++) vectors[i] = 12'hfff; // end marker
		$readmemh("testbench/rps_game_vectors.txt", vectors);
		repeat (10) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		if (play_ack !== 1'b0) begin
			$display("MISMATCH play_ack: got %h, expected 0", play_ack);
			abort_run();
		end
		check_results(rps_pkg::move_rock); // everything reads zero
		idx = 0;
		while (idx < 64 && vectors[idx] != 12'hfff) begin
			vec = vectors[idx];
			@(posedge clock);
			strategy <= rps_pkg::strategy_t'(vec[8]);
			user_move <= rps_pkg::move_t'(vec[5:4]);
			play_req <= 1'b1;
			model_round(rps_pkg::strategy_t'(vec[8]), rps_pkg::move_t'(vec[5:4]));
			wait_for_ack(1'b1);
			check_results(rps_pkg::move_t'(vec[5:4]));
			repeat (int'(vec[3:0])) begin // request held high starts no second round
				@(negedge clock);
				if (play_ack !== 1'b1) begin
					$display("MISMATCH play_ack: got %h, expected 1", play_ack);
					abort_run();
				end
				check_results(rps_pkg::move_t'(vec[5:4]));
			end
			@(posedge clock);
			play_req <= 1'b0;
			wait_for_ack(1'b0);
			idx++;
		end
		if (idx == 0) begin
			$display("no rounds were read from the vector file");
			abort_run();
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- testbench/rps_game_vectors.txt
// one round per word: strategy digit (0 rotate, 1 markov), user move digit (3 illegal),
// then the extra cycles that play_req stays high after play_ack
000
010
020
030
002
103
100
100
110
120
130
100
113
021
100
120
100
